//--- src/hash_tx_pkg.sv
// Hash frame format constants
package hash_tx_pkg;

	// Stream word and hash halfword width
	localparam int WORD_W = 16;

	// Packet identifier width, sits in the low half of the header
	localparam int PID_W = 8;

	// Upper byte of every header word
	localparam logic [WORD_W-PID_W-1:0] SYNC_BYTE = 8'h54;

	// Hash payload, sent from the top halfword down
	localparam int HASH_WORDS = 18;

	// First sequence value after reset
	localparam logic [WORD_W-1:0] SEQ_INIT = 16'd1;

	// Header plus sequence word plus hash
	localparam int FRAME_WORDS = HASH_WORDS + 2;

	// Word index within a frame
	localparam int IDX_W = $clog2(FRAME_WORDS);

	// Fixed word positions
	localparam logic [IDX_W-1:0] HDR_IDX = 0;
	localparam logic [IDX_W-1:0] SEQ_IDX = 1;
	localparam logic [IDX_W-1:0] FIRST_HASH_IDX = 2;

	// Halfword 0, carries the last flag
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_WORDS - 1);

endpackage

//--- src/hash_tx_regs_pkg.sv
// Hash transmitter register map
package hash_tx_regs_pkg;

	// Write address width
	localparam int CFG_ADDR_W = 5;

	// Addresses 0 to 17 hold the hash halfwords
	// Address 18 is control and anything above is accepted and dropped
	localparam logic [CFG_ADDR_W-1:0] CTRL_ADDR = 5'd18;

	// Spare bits between start and PID
	localparam int CTRL_RSVD_W = hash_tx_pkg::WORD_W - hash_tx_pkg::PID_W - 1;

	// Control register layout
	typedef struct packed {
		// Launch a frame on write
		logic start;
		// Ignored by the register block
		logic [CTRL_RSVD_W-1:0] rsvd;
		// Packet identifier for the header word
		logic [hash_tx_pkg::PID_W-1:0] pid;
	} ctrl_fields_t;

	// One write data word seen two ways
	// raw for a hash halfword, ctrl for the control register
	typedef union packed {
		logic [hash_tx_pkg::WORD_W-1:0] raw;
		ctrl_fields_t ctrl;
	} cfg_word_u;

endpackage

//--- src/hash_frame_if.sv
// Register block to serializer link
interface hash_frame_if;

	// Hash halfwords, index 17 goes out first
	logic [hash_tx_pkg::HASH_WORDS-1:0][hash_tx_pkg::WORD_W-1:0] hash;

	// PID for the header word
	logic [hash_tx_pkg::PID_W-1:0] pid;

	// Single cycle launch request
	logic start;

	// High from the header word until the last word is taken
	logic busy;

	modport regs_mp (
		output hash,
		output pid,
		output start,
		input  busy
	);

	modport framer_mp (
		input  hash,
		input  pid,
		input  start,
		output busy
	);

endinterface

//--- src/hash_tx_regs.sv
// Hash transmitter register block
module hash_tx_regs (
	input  logic tb_clk,
	input  logic reset,

	// Host write port
	input  logic cfg_valid,
	output logic cfg_ready,
	input  logic [hash_tx_regs_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [hash_tx_pkg::WORD_W-1:0] cfg_wdata,

	// Toward the serializer
	hash_frame_if.regs_mp frame
);

	// Stored hash, PID and launch pulse
	logic [hash_tx_pkg::HASH_WORDS-1:0][hash_tx_pkg::WORD_W-1:0] hash_q;
	logic [hash_tx_pkg::PID_W-1:0] pid_q;
	logic start_q;

	// Write decode
	logic accept;
	logic ctrl_hit;
	hash_tx_regs_pkg::cfg_word_u wr_word;

	// Same data word, read as raw or as control fields
	assign wr_word.raw = cfg_wdata;

	assign accept = cfg_valid && cfg_ready;
	assign ctrl_hit = accept && (cfg_addr == hash_tx_regs_pkg::CTRL_ADDR);

	// Writes held off while a frame runs and in the launch cycle
	// so the hash cannot change under the serializer
	assign cfg_ready = !frame.busy && !start_q;

	// Hash halfwords
	always_ff @(posedge tb_clk) begin
		if (reset) begin
			hash_q <= '0;
		end else if (accept) begin
			for (int i = 0; i < hash_tx_pkg::HASH_WORDS; i++) begin
				if (int'(cfg_addr) == i) begin
					hash_q[i] <= wr_word.raw;
				end
			end
		end
	end

	// PID follows every control write, start or not
	always_ff @(posedge tb_clk) begin
		if (reset) begin
			pid_q <= '0;
		end else if (ctrl_hit) begin
			pid_q <= wr_word.ctrl.pid;
		end
	end

	// Launch pulse, one cycle after the control write
	always_ff @(posedge tb_clk) begin
		if (reset) begin
			start_q <= 1'b0;
		end else begin
			start_q <= ctrl_hit && wr_word.ctrl.start;
		end
	end

	// Out to the serializer
	assign frame.hash = hash_q;
	assign frame.pid = pid_q;
	assign frame.start = start_q;

endmodule

//--- src/hash_frame_serializer.sv
// Hash frame serializer
module hash_frame_serializer (
	input  logic tb_clk,
	input  logic reset,

	// From the register block
	hash_frame_if.framer_mp frame,

	// Output word stream
	output logic tx_valid,
	input  logic tx_ready,
	output logic [hash_tx_pkg::WORD_W-1:0] tx_data,
	output logic tx_last
);

	// Frame state
	logic busy_q;
	logic last_q;
	logic [hash_tx_pkg::IDX_W-1:0] idx_q;
	logic [hash_tx_pkg::WORD_W-1:0] seq_q;

	// Next word selection
	logic launch;
	logic accept;
	logic load;
	logic [hash_tx_pkg::IDX_W-1:0] idx_next;
	logic [hash_tx_pkg::WORD_W-1:0] word_next;
	int hash_sel;

	// Start only matters when idle
	assign launch = frame.start && !busy_q;
	assign accept = busy_q && tx_ready;

	// New word on launch or after any word but the last
	assign load = launch || (accept && !last_q);

	// Index of the word about to be presented
	assign idx_next = launch ? hash_tx_pkg::HDR_IDX : idx_q + 1'b1;

	// Index 2 maps to halfword 17, index 19 to halfword 0
	assign hash_sel = hash_tx_pkg::HASH_WORDS - 1 + int'(hash_tx_pkg::FIRST_HASH_IDX)
		- int'(idx_next);

	always_comb begin
		case (idx_next)
			hash_tx_pkg::HDR_IDX: begin
				word_next = {hash_tx_pkg::SYNC_BYTE, frame.pid};
			end
			hash_tx_pkg::SEQ_IDX: begin
				word_next = seq_q;
			end
			default: begin
				word_next = frame.hash[hash_sel];
			end
		endcase
	end

	// Control path
	always_ff @(posedge tb_clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			last_q <= 1'b0;
			idx_q <= '0;
			seq_q <= hash_tx_pkg::SEQ_INIT;
		end else if (launch) begin
			busy_q <= 1'b1;
			last_q <= 1'b0;
			idx_q <= idx_next;
		end else if (accept) begin
			if (last_q) begin
				// Frame done, counter wraps at 16 bits
				busy_q <= 1'b0;
				last_q <= 1'b0;
				seq_q <= seq_q + 1'b1;
			end else begin
				idx_q <= idx_next;
				last_q <= (idx_next == hash_tx_pkg::LAST_IDX);
			end
		end
	end

	// Output word, held while the sink stalls
	always_ff @(posedge tb_clk) begin
		if (load) begin
			tx_data <= word_next;
		end
	end

	assign tx_valid = busy_q;
	assign tx_last = last_q;
	assign frame.busy = busy_q;

endmodule

//--- src/hash_tx_top.sv
// Hash packet transmitter
module hash_tx_top (
	input  logic tb_clk,
	input  logic reset,

	// Host write port
	input  logic cfg_valid,
	output logic cfg_ready,
	input  logic [hash_tx_regs_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [hash_tx_pkg::WORD_W-1:0] cfg_wdata,

	// Frame word stream
	output logic tx_valid,
	input  logic tx_ready,
	output logic [hash_tx_pkg::WORD_W-1:0] tx_data,
	output logic tx_last,

	// High for the length of a frame
	output logic frame_busy
);

	// Hash, PID, start and busy between the two blocks
	hash_frame_if frame_bus ();

	hash_tx_regs u_regs (
		.tb_clk    (tb_clk),
		.reset     (reset),
		.cfg_valid (cfg_valid),
		.cfg_ready (cfg_ready),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.frame     (frame_bus.regs_mp)
	);

	hash_frame_serializer u_serializer (
		.tb_clk   (tb_clk),
		.reset    (reset),
		.frame    (frame_bus.framer_mp),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_data  (tx_data),
		.tx_last  (tx_last)
	);

	// Serializer busy doubles as the status output
	assign frame_busy = frame_bus.busy;

endmodule

//--- bench/tb_hash_tx.sv
// Hash transmitter testbench
module tb_hash_tx;

	logic tb_clk;
	logic reset;
	logic cfg_valid;
	logic cfg_ready;
	logic [hash_tx_regs_pkg::CFG_ADDR_W-1:0] cfg_addr;
	logic [hash_tx_pkg::WORD_W-1:0] cfg_wdata;
	logic tx_valid;
	logic tx_ready;
	logic [hash_tx_pkg::WORD_W-1:0] tx_data;
	logic tx_last;
	logic frame_busy;

	// Expected words with the last flag in the top bit
	logic [hash_tx_pkg::WORD_W:0] exp_q[$];
	logic [hash_tx_pkg::WORD_W-1:0] exp_word;
	logic exp_last;
	int exp_count;
	logic took;

	// Model of the hash registers and the frame counter
	logic [hash_tx_pkg::WORD_W-1:0] hash_model [hash_tx_pkg::HASH_WORDS];
	logic [hash_tx_pkg::WORD_W-1:0] model_seq;
	logic rand_ready;
	int errors;
	int tests_run;
	int tests_failed;

	hash_tx_top UUT (
		.tb_clk     (tb_clk),
		.reset      (reset),
		.cfg_valid  (cfg_valid),
		.cfg_ready  (cfg_ready),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.tx_valid   (tx_valid),
		.tx_ready   (tx_ready),
		.tx_data    (tx_data),
		.tx_last    (tx_last),
		.frame_busy (frame_busy)
	);

	initial begin
		tb_clk = 1'b0;
		forever #2 tb_clk = ~tb_clk;
	end

	// Sink readiness is random while back-pressure is on
	initial begin
		forever begin
			@(posedge tb_clk);
			#1;
			tx_ready = rand_ready ? (($urandom % 4) != 0) : 1'b1;
		end
	end

	// Every accepted word must match the head of the model queue
	word_expected: assert property (@(posedge tb_clk) disable iff (reset)
		(tx_valid && tx_ready) |-> (exp_count > 0))
	else begin
		$display("Word accepted at t=%0t while no word was expected", $time);
		errors++;
	end

	data_match: assert property (@(posedge tb_clk) disable iff (reset)
		(tx_valid && tx_ready) |-> (exp_count == 0 || tx_data == exp_word))
	else begin
		$display("ERR t=%0t tx_data expected %h got %h", $time,
			$sampled(exp_word), $sampled(tx_data));
		errors++;
	end

	last_match: assert property (@(posedge tb_clk) disable iff (reset)
		(tx_valid && tx_ready) |-> (exp_count == 0 || tx_last == exp_last))
	else begin
		$display("ERR t=%0t tx_last expected %b got %b", $time,
			$sampled(exp_last), $sampled(tx_last));
		errors++;
	end

	// Retire the head half a cycle after each accepted word
	always @(posedge tb_clk) begin
		took <= !reset && tx_valid && tx_ready;
	end

	always @(negedge tb_clk) begin
		if (took) begin
			if (exp_q.size() > 0) begin
				void'(exp_q.pop_front());
			end
			refresh_head();
		end
	end

	task automatic refresh_head();
		exp_count = exp_q.size();
		if (exp_count > 0) begin
			exp_word = exp_q[0][hash_tx_pkg::WORD_W-1:0];
			exp_last = exp_q[0][hash_tx_pkg::WORD_W];
		end else begin
			exp_word = '0;
			exp_last = 1'b0;
		end
	endtask

	task automatic next_cycle();
		@(posedge tb_clk);
		#1;
	endtask

	task automatic report_hang(input string what);
		$display("Timeout at t=%0t, %s", $time, what);
		$display("TEST FAILED");
		$finish;
	endtask

	// One register write that reports how many cycles it waited for cfg_ready
	task automatic write_reg(input logic [hash_tx_regs_pkg::CFG_ADDR_W-1:0] addr,
		input logic [hash_tx_pkg::WORD_W-1:0] data, output int waited);
		waited = 0;
		cfg_valid = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		while (!cfg_ready) begin
			next_cycle();
			waited++;
			if (waited > 200) begin
				report_hang("a register write was never accepted");
			end
		end
		next_cycle();
		cfg_valid = 1'b0;
	endtask

	task automatic write_hash(input int idx, input logic [hash_tx_pkg::WORD_W-1:0] value,
		output int waited);
		hash_tx_regs_pkg::cfg_word_u w;
		w.raw = value;
		write_reg(idx[hash_tx_regs_pkg::CFG_ADDR_W-1:0], w.raw, waited);
		hash_model[idx] = value;
	endtask

	task automatic write_ctrl(input logic start, input logic [hash_tx_pkg::PID_W-1:0] pid);
		hash_tx_regs_pkg::cfg_word_u w;
		int waited;
		w.ctrl.start = start;
		w.ctrl.rsvd = '0;
		w.ctrl.pid = pid;
		write_reg(hash_tx_regs_pkg::CTRL_ADDR, w.raw, waited);
	endtask

	task automatic fill_hash();
		int waited;
		for (int i = 0; i < hash_tx_pkg::HASH_WORDS; i++) begin
			write_hash(i, hash_tx_pkg::WORD_W'($urandom), waited);
		end
	endtask

	// Header, sequence number, then hash from the top halfword down
	task automatic push_frame(input logic [hash_tx_pkg::PID_W-1:0] pid);
		exp_q.push_back({1'b0, hash_tx_pkg::SYNC_BYTE, pid});
		exp_q.push_back({1'b0, model_seq});
		for (int i = hash_tx_pkg::HASH_WORDS - 1; i >= 0; i--) begin
			exp_q.push_back({(i == 0), hash_model[i]});
		end
		model_seq = model_seq + 16'd1;
		refresh_head();
	endtask

	// Wait for busy to rise, then count its cycles until it falls
	task automatic wait_frame(output int busy_cycles);
		int n;
		n = 0;
		while (!frame_busy) begin
			next_cycle();
			n++;
			if (n > 50) begin
				report_hang("frame_busy never rose after a start write");
			end
		end
		busy_cycles = 0;
		while (frame_busy) begin
			next_cycle();
			busy_cycles++;
			if (busy_cycles > 400) begin
				report_hang("a frame never reached tx_last");
			end
		end
		// Last word still has to leave the model queue
		n = 0;
		while (took) begin
			next_cycle();
			n++;
			if (n > 4) begin
				report_hang("the last word never retired from the model queue");
			end
		end
	endtask

	task automatic check_drained();
		assert (exp_count == 0) else begin
			$display("Frame ended with %0d expected words not sent", exp_count);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int base);
		tests_run++;
		if (errors != base) begin
			tests_failed++;
		end
		$display("%s: %s", name, (errors == base) ? "ok" : "failed");
	endtask

	initial begin
		int cycles;
		int waited;
		int base;
		logic [hash_tx_pkg::PID_W-1:0] pid;
		void'($urandom(32'h2b7acb13));
		reset = 1'b1;
		cfg_valid = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		tx_ready = 1'b1;
		rand_ready = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		model_seq = hash_tx_pkg::SEQ_INIT;
		for (int i = 0; i < hash_tx_pkg::HASH_WORDS; i++) begin
			hash_model[i] = '0;
		end
		refresh_head();
		repeat (8) @(posedge tb_clk);
		#1;
		reset = 1'b0;

		base = errors;
		assert (!tx_valid) else begin
			$display("ERR t=%0t tx_valid expected 0 got %b", $time, tx_valid);
			errors++;
		end
		assert (!frame_busy) else begin
			$display("ERR t=%0t frame_busy expected 0 got %b", $time, frame_busy);
			errors++;
		end
		assert (cfg_ready) else begin
			$display("ERR t=%0t cfg_ready expected 1 got %b", $time, cfg_ready);
			errors++;
		end
		end_test("reset state", base);

		// Sink always ready so busy lasts one cycle per word
		base = errors;
		fill_hash();
		pid = 8'hc3;
		push_frame(pid);
		write_ctrl(1'b1, pid);
		wait_frame(cycles);
		assert (cycles == 20) else begin
			$display("ERR t=%0t frame_busy cycles expected 20 got %0d", $time, cycles);
			errors++;
		end
		check_drained();
		end_test("full frame", base);

		base = errors;
		rand_ready = 1'b1;
		fill_hash();
		pid = 8'h1e;
		push_frame(pid);
		write_ctrl(1'b1, pid);
		wait_frame(cycles);
		check_drained();
		end_test("back-pressure", base);

		// Hash write issued right after launch has to wait for the frame
		base = errors;
		pid = 8'h5a;
		push_frame(pid);
		write_ctrl(1'b1, pid);
		write_hash(5, 16'hbeef, waited);
		assert (waited > 0) else begin
			$display("Hash write at t=%0t was accepted during a frame", $time);
			errors++;
		end
		check_drained();
		push_frame(pid);
		write_ctrl(1'b1, pid);
		wait_frame(cycles);
		check_drained();
		rand_ready = 1'b0;
		end_test("stalled writes", base);

		base = errors;
		pid = 8'ha7;
		write_ctrl(1'b0, pid);
		for (int i = 0; i < 40; i++) begin
			assert (!tx_valid) else begin
				$display("ERR t=%0t tx_valid expected 0 got %b", $time, tx_valid);
				errors++;
			end
			next_cycle();
		end
		push_frame(pid);
		write_ctrl(1'b1, pid);
		wait_frame(cycles);
		check_drained();
		end_test("control write without start", base);

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
src/hash_tx_pkg.sv
src/hash_tx_regs_pkg.sv
src/hash_frame_if.sv
src/hash_tx_regs.sv
src/hash_frame_serializer.sv
src/hash_tx_top.sv
bench/tb_hash_tx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the hash transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_hash_tx \
	--Mdir obj_dir \
	-o sim_tb_hash_tx \
	-f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb_hash_tx)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi
